// ==== build.f ====
+incdir+logic
logic/sfu_op_pkg.sv
logic/sfu_csr_pkg.sv
logic/sfu_pe_switch.sv
logic/sfu_warp_ctl.sv
logic/sfu_csr_file.sv
logic/sfu_unit.sv
tests/sfu_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the special-function unit testbench

VERILATOR ?= verilator
TOP       ?= sfu_unit_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := logic/sfu_cfg.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST) tests/sfu_input.txt
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/sfu_input.txt ====
# op wid tmask csr_addr rs1 rs2 retire iso exp_wb exp_data strobe_kind strobe_v1 strobe_v2
# op: 0 TMC 1 WSPAWN 2 BAR 3 CSRRW 4 CSRRS 5 CSRRC, strobe_kind: 0 none 1 tmc 2 spawn 3 release
3 1 f 340 12345678 0 0 1 1 00000000 0 0 0
4 1 f 340 000000f0 0 0 0 1 12345678 0 0 0
5 1 f 340 12000008 0 0 0 1 123456f8 0 0 0
3 1 f 340 00000000 0 0 0 1 003456f0 0 0 0
4 5 f cc1 ffffffff 0 0 0 1 00000005 0 0 0
4 0 f cc2 00000000 0 0 0 1 00000003 0 0 0
3 0 a cc4 ffffffff 0 0 0 1 0000000a 0 0 0
3 0 f fc1 00000001 0 0 0 1 00000008 0 0 0
4 0 f b02 00000000 0 1 0 1 00000001 0 0 0
3 0 f b02 00000055 0 1 0 1 00000002 0 0 0
4 0 f b02 ffffffff 0 0 0 1 00000002 0 0 0
3 0 f 123 0000ffff 0 0 0 1 00000000 0 0 0
4 0 f 123 00000000 0 0 0 1 00000000 0 0 0
0 2 f 000 0000000b 0 0 0 0 00000000 1 b 0
0 7 f 000 fffffff6 0 0 1 0 00000000 1 6 0
1 0 f 000 000000f0 80001000 0 0 0 00000000 2 f0 80001000
1 0 f 000 00000103 00000400 0 0 0 00000000 2 03 00000400
2 0 f 000 00000000 00000003 0 0 0 00000000 0 0 0
2 4 f 000 00000001 00000002 0 0 0 00000000 0 0 0
2 2 f 000 00000000 00000003 0 0 0 00000000 0 0 0
2 6 f 000 00000000 00000003 0 0 0 00000000 3 45 0
2 5 f 000 00000001 00000002 0 0 0 00000000 3 30 0
2 3 f 000 00000000 00000001 0 0 0 00000000 3 08 0
4 0 f 340 000000a5 0 0 0 1 00000000 0 0 0
5 0 f 340 0000000f 0 0 0 1 000000a5 0 0 0
4 0 f 340 00000000 0 0 1 1 000000a0 0 0 0
0 1 f 000 00000001 0 0 0 0 00000000 1 1 0
4 0 f b02 00000000 0 0 0 1 00000002 0 0 0
1 0 f 000 000000ff 00000000 0 0 0 00000000 2 ff 0
4 3 c cc1 00000000 0 0 0 1 00000003 0 0 0

// ==== tests/sfu_unit_tb.sv ====
/*
 * Testbench of the special-function unit
 * Vector-driven requests, random commit stalls, a uuid scoreboard
 * and checks of commits, strobes and isolated-request latency
 */

`timescale 1ns/1ps

module sfu_unit_tb;

    localparam int MAX_VEC = 64;

    logic clk;
    logic arst_n;
    logic req_valid;
    sfu_op_pkg::uuid_t req_uuid;
    sfu_op_pkg::wid_t req_wid;
    sfu_op_pkg::tmask_t req_tmask;
    sfu_op_pkg::sfu_op_t req_op;
    sfu_csr_pkg::csr_addr_t req_csr_addr;
    sfu_op_pkg::xdata_t req_rs1;
    sfu_op_pkg::xdata_t req_rs2;
    logic req_ready;
    logic retire;
    logic commit_ready;
    logic commit_valid;
    sfu_op_pkg::uuid_t commit_uuid;
    sfu_op_pkg::wid_t commit_wid;
    sfu_op_pkg::tmask_t commit_tmask;
    logic commit_wb;
    sfu_op_pkg::xdata_t commit_data;
    logic tmc_valid;
    sfu_op_pkg::wid_t tmc_wid;
    sfu_op_pkg::tmask_t tmc_mask;
    logic spawn_valid;
    sfu_op_pkg::wmask_t spawn_mask;
    sfu_op_pkg::xdata_t spawn_pc;
    logic bar_release_valid;
    sfu_op_pkg::wmask_t bar_release_mask;

    // Vector columns, see the data file
    logic [31:0] v_op [MAX_VEC];
    logic [31:0] v_wid [MAX_VEC];
    logic [31:0] v_tmask [MAX_VEC];
    logic [31:0] v_addr [MAX_VEC];
    logic [31:0] v_rs1 [MAX_VEC];
    logic [31:0] v_rs2 [MAX_VEC];
    logic [31:0] v_ret [MAX_VEC];
    logic [31:0] v_iso [MAX_VEC];
    logic [31:0] v_wb [MAX_VEC];
    logic [31:0] v_data [MAX_VEC];
    logic [31:0] v_skind [MAX_VEC];
    logic [31:0] v_sv1 [MAX_VEC];
    logic [31:0] v_sv2 [MAX_VEC];

    // Scoreboard indexed by uuid
    bit exp_open [MAX_VEC];
    int acc_edge [MAX_VEC];
    int vec_err [MAX_VEC];

    int n_vec = 0;
    int pending = 0;
    int errors = 0;
    int n_done = 0;
    int n_ok = 0;
    int cyc = 0;
    bit force_ready = 0;

    // Strobe expected one cycle after an acceptance
    bit st_pend = 0;
    int st_id;

    sfu_unit UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        commit_ready <= force_ready || ($urandom % 4 != 0);
    end

    task automatic check(string name, logic [31:0] got, logic [31:0] exp, int id);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h (vector %0d)", $time, name, got, exp, id);
            errors++;
            vec_err[id]++;
        end
    endtask

    task automatic load_vectors();
        int fd;
        int cnt;
        string line;
        fd = $fopen("tests/sfu_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                v_op[n_vec], v_wid[n_vec], v_tmask[n_vec], v_addr[n_vec], v_rs1[n_vec],
                v_rs2[n_vec], v_ret[n_vec], v_iso[n_vec], v_wb[n_vec], v_data[n_vec],
                v_skind[n_vec], v_sv1[n_vec], v_sv2[n_vec]);
            if (cnt == 13 && n_vec < MAX_VEC) begin
                n_vec++;
            end
        end
        $fclose(fd);
    endtask

    // Strobes are sampled mid-cycle, exactly one per accepted TMC, WSPAWN or releasing BAR
    always @(negedge clk) begin
        if (arst_n && st_pend) begin
            check("tmc_valid", 32'(tmc_valid), 32'(v_skind[st_id] == 1), st_id);
            check("spawn_valid", 32'(spawn_valid), 32'(v_skind[st_id] == 2), st_id);
            check("bar_release_valid", 32'(bar_release_valid), 32'(v_skind[st_id] == 3), st_id);
            if (v_skind[st_id] == 1) begin
                check("tmc_wid", 32'(tmc_wid), v_wid[st_id], st_id);
                check("tmc_mask", 32'(tmc_mask), v_sv1[st_id], st_id);
            end
            if (v_skind[st_id] == 2) begin
                check("spawn_mask", 32'(spawn_mask), v_sv1[st_id], st_id);
                check("spawn_pc", spawn_pc, v_sv2[st_id], st_id);
            end
            if (v_skind[st_id] == 3) begin
                check("bar_release_mask", 32'(bar_release_mask), v_sv1[st_id], st_id);
            end
            st_pend = 0;
        end else if (arst_n && (tmc_valid || spawn_valid || bar_release_valid)) begin
            $display("Strobe fired with no accepted request at %0t", $time);
            errors++;
        end
    end

    // Commit handshake completes at the next rising edge
    always @(negedge clk) begin
        int id;
        sfu_op_pkg::sfu_op_t op;
        if (arst_n && commit_valid && commit_ready) begin
            id = int'(commit_uuid);
            if (id >= n_vec || !exp_open[id]) begin
                $display("Commit of unknown or repeated uuid %0d at %0t", id, $time);
                errors++;
            end else begin
                check("commit_wid", 32'(commit_wid), v_wid[id], id);
                check("commit_tmask", 32'(commit_tmask), v_tmask[id], id);
                check("commit_wb", 32'(commit_wb), v_wb[id], id);
                check("commit_data", commit_data, v_data[id], id);
                if (v_iso[id] != 0) begin
                    check("commit latency", 32'(cyc + 1 - acc_edge[id]), 32'd2, id);
                end
                exp_open[id] = 0;
                pending--;
                n_done++;
                if (vec_err[id] == 0) begin
                    n_ok++;
                end
                op = sfu_op_pkg::sfu_op_t'(v_op[id][2:0]);
                $display("vector %0d %s: %s", id, op.name(),
                    (vec_err[id] == 0) ? "ok" : "FAILED");
            end
        end
    end

    initial begin
        wait (n_vec > 0);
        repeat (n_vec * 20 + 100) @(posedge clk);
        $display("Timeout with %0d commits still missing", pending);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h561d6921));
        arst_n = 1'b0;
        req_valid = 1'b0;
        req_uuid = '0;
        req_wid = '0;
        req_tmask = '0;
        req_op = sfu_op_pkg::TMC;
        req_csr_addr = '0;
        req_rs1 = '0;
        req_rs2 = '0;
        retire = 1'b0;
        commit_ready = 1'b0;
        load_vectors();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < n_vec; i++) begin
            if (v_ret[i] != 0) begin
                req_valid <= 1'b0;
                retire <= 1'b1;
                @(posedge clk);
                retire <= 1'b0;
            end
            if (v_iso[i] != 0) begin
                // Drain everything, then hold commit_ready high for a clean latency
                req_valid <= 1'b0;
                @(negedge clk);
                force_ready = 1;
                while (pending != 0) begin
                    @(posedge clk);
                end
                repeat (2) @(posedge clk);
            end
            req_valid <= 1'b1;
            req_uuid <= 8'(i);
            req_wid <= 3'(v_wid[i]);
            req_tmask <= 4'(v_tmask[i]);
            req_op <= sfu_op_pkg::sfu_op_t'(v_op[i][2:0]);
            req_csr_addr <= 12'(v_addr[i]);
            req_rs1 <= v_rs1[i];
            req_rs2 <= v_rs2[i];
            @(negedge clk);
            while (!req_ready) begin
                @(negedge clk);
            end
            acc_edge[i] = cyc + 1;
            @(posedge clk);
            exp_open[i] = 1;
            pending++;
            st_id = i;
            st_pend = 1;
            if (v_iso[i] != 0) begin
                req_valid <= 1'b0;
                while (pending != 0) begin
                    @(posedge clk);
                end
                @(negedge clk);
                force_ready = 0;
                @(posedge clk);
            end
        end
        req_valid <= 1'b0;
        while (pending != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        $display("%0d vectors, %0d committed, %0d clean, %0d errors",
            n_vec, n_done, n_ok, errors);
        if (errors == 0 && n_done == n_vec && n_vec > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== logic/sfu_unit.sv ====
/*
 * Special-function unit top level
 * Connects the request switch, the warp-control element and the CSR element
 */

`timescale 1ns/1ps

module sfu_unit (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    req_valid,
    input  sfu_op_pkg::uuid_t       req_uuid,
    input  sfu_op_pkg::wid_t        req_wid,
    input  sfu_op_pkg::tmask_t      req_tmask,
    input  sfu_op_pkg::sfu_op_t     req_op,
    input  sfu_csr_pkg::csr_addr_t  req_csr_addr,
    input  sfu_op_pkg::xdata_t      req_rs1,
    input  sfu_op_pkg::xdata_t      req_rs2,
    output logic                    req_ready,

    input  logic                    retire,
    input  logic                    commit_ready,
    output logic                    commit_valid,
    output sfu_op_pkg::uuid_t       commit_uuid,
    output sfu_op_pkg::wid_t        commit_wid,
    output sfu_op_pkg::tmask_t      commit_tmask,
    output logic                    commit_wb,
    output sfu_op_pkg::xdata_t      commit_data,

    output logic                    tmc_valid,
    output sfu_op_pkg::wid_t        tmc_wid,
    output sfu_op_pkg::tmask_t      tmc_mask,
    output logic                    spawn_valid,
    output sfu_op_pkg::wmask_t      spawn_mask,
    output sfu_op_pkg::xdata_t      spawn_pc,
    output logic                    bar_release_valid,
    output sfu_op_pkg::wmask_t      bar_release_mask
);

    // Execute fields shared by both elements
    sfu_op_pkg::uuid_t       exec_uuid;
    sfu_op_pkg::wid_t        exec_wid;
    sfu_op_pkg::tmask_t      exec_tmask;
    sfu_op_pkg::sfu_op_t     exec_op;
    sfu_csr_pkg::csr_addr_t  exec_csr_addr;
    sfu_op_pkg::xdata_t      exec_rs1;
    sfu_op_pkg::xdata_t      exec_rs2;

    logic                    wctl_valid;
    logic                    wctl_ready;
    logic                    wctl_res_valid;
    sfu_op_pkg::uuid_t       wctl_res_uuid;
    sfu_op_pkg::wid_t        wctl_res_wid;
    sfu_op_pkg::tmask_t      wctl_res_tmask;
    logic                    wctl_res_wb;
    sfu_op_pkg::xdata_t      wctl_res_data;
    logic                    wctl_res_ready;

    logic                    csr_valid;
    logic                    csr_ready;
    logic                    csr_res_valid;
    sfu_op_pkg::uuid_t       csr_res_uuid;
    sfu_op_pkg::wid_t        csr_res_wid;
    sfu_op_pkg::tmask_t      csr_res_tmask;
    logic                    csr_res_wb;
    sfu_op_pkg::xdata_t      csr_res_data;
    logic                    csr_res_ready;

    sfu_pe_switch pe_switch (
        .clk            (clk),
        .arst_n         (arst_n),
        .req_valid      (req_valid),
        .req_uuid       (req_uuid),
        .req_wid        (req_wid),
        .req_tmask      (req_tmask),
        .req_op         (req_op),
        .req_csr_addr   (req_csr_addr),
        .req_rs1        (req_rs1),
        .req_rs2        (req_rs2),
        .req_ready      (req_ready),
        .commit_valid   (commit_valid),
        .commit_uuid    (commit_uuid),
        .commit_wid     (commit_wid),
        .commit_tmask   (commit_tmask),
        .commit_wb      (commit_wb),
        .commit_data    (commit_data),
        .commit_ready   (commit_ready),
        .exec_uuid      (exec_uuid),
        .exec_wid       (exec_wid),
        .exec_tmask     (exec_tmask),
        .exec_op        (exec_op),
        .exec_csr_addr  (exec_csr_addr),
        .exec_rs1       (exec_rs1),
        .exec_rs2       (exec_rs2),
        .wctl_valid     (wctl_valid),
        .wctl_ready     (wctl_ready),
        .csr_valid      (csr_valid),
        .csr_ready      (csr_ready),
        .wctl_res_valid (wctl_res_valid),
        .wctl_res_uuid  (wctl_res_uuid),
        .wctl_res_wid   (wctl_res_wid),
        .wctl_res_tmask (wctl_res_tmask),
        .wctl_res_wb    (wctl_res_wb),
        .wctl_res_data  (wctl_res_data),
        .wctl_res_ready (wctl_res_ready),
        .csr_res_valid  (csr_res_valid),
        .csr_res_uuid   (csr_res_uuid),
        .csr_res_wid    (csr_res_wid),
        .csr_res_tmask  (csr_res_tmask),
        .csr_res_wb     (csr_res_wb),
        .csr_res_data   (csr_res_data),
        .csr_res_ready  (csr_res_ready)
    );

    sfu_warp_ctl warp_ctl (
        .clk               (clk),
        .arst_n            (arst_n),
        .exec_valid        (wctl_valid),
        .exec_uuid         (exec_uuid),
        .exec_wid          (exec_wid),
        .exec_tmask        (exec_tmask),
        .exec_op           (exec_op),
        .exec_rs1          (exec_rs1),
        .exec_rs2          (exec_rs2),
        .exec_ready        (wctl_ready),
        .res_valid         (wctl_res_valid),
        .res_uuid          (wctl_res_uuid),
        .res_wid           (wctl_res_wid),
        .res_tmask         (wctl_res_tmask),
        .res_wb            (wctl_res_wb),
        .res_data          (wctl_res_data),
        .res_ready         (wctl_res_ready),
        .tmc_valid         (tmc_valid),
        .tmc_wid           (tmc_wid),
        .tmc_mask          (tmc_mask),
        .spawn_valid       (spawn_valid),
        .spawn_mask        (spawn_mask),
        .spawn_pc          (spawn_pc),
        .bar_release_valid (bar_release_valid),
        .bar_release_mask  (bar_release_mask)
    );

    sfu_csr_file csr_file (
        .clk           (clk),
        .arst_n        (arst_n),
        .exec_valid    (csr_valid),
        .exec_uuid     (exec_uuid),
        .exec_wid      (exec_wid),
        .exec_tmask    (exec_tmask),
        .exec_op       (exec_op),
        .exec_csr_addr (exec_csr_addr),
        .exec_rs1      (exec_rs1),
        .retire        (retire),
        .exec_ready    (csr_ready),
        .res_valid     (csr_res_valid),
        .res_uuid      (csr_res_uuid),
        .res_wid       (csr_res_wid),
        .res_tmask     (csr_res_tmask),
        .res_wb        (csr_res_wb),
        .res_data      (csr_res_data),
        .res_ready     (csr_res_ready)
    );

endmodule

// ==== logic/sfu_csr_file.sv ====
/*
 * CSR element
 * Scratch register, retired-instruction counter and the read-only
 * identification CSRs, with read-write, set and clear accesses
 */

`timescale 1ns/1ps

`include "sfu_cfg.svh"

module sfu_csr_file (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    exec_valid,
    input  sfu_op_pkg::uuid_t       exec_uuid,
    input  sfu_op_pkg::wid_t        exec_wid,
    input  sfu_op_pkg::tmask_t      exec_tmask,
    input  sfu_op_pkg::sfu_op_t     exec_op,
    input  sfu_csr_pkg::csr_addr_t  exec_csr_addr,
    input  sfu_op_pkg::xdata_t      exec_rs1,
    input  logic                    retire,
    output logic                    exec_ready,

    output logic                    res_valid,
    output sfu_op_pkg::uuid_t       res_uuid,
    output sfu_op_pkg::wid_t        res_wid,
    output sfu_op_pkg::tmask_t      res_tmask,
    output logic                    res_wb,
    output sfu_op_pkg::xdata_t      res_data,
    input  logic                    res_ready
);

    logic                fire;
    logic                scratch_wr;
    sfu_op_pkg::xdata_t  rd_data;
    sfu_op_pkg::xdata_t  wr_data;
    sfu_op_pkg::xdata_t  scratch;
    sfu_op_pkg::xdata_t  instret;

    assign exec_ready = !res_valid || res_ready;
    assign fire       = exec_valid && exec_ready;

    // Every CSR access returns the old value to the register file
    assign res_wb = 1'b1;

    always_comb begin
        case (exec_csr_addr)
            sfu_csr_pkg::CSR_SCRATCH:   rd_data = scratch;
            sfu_csr_pkg::CSR_WARP_ID:   rd_data = sfu_op_pkg::xdata_t'(exec_wid);
            sfu_csr_pkg::CSR_CORE_ID:   rd_data = sfu_op_pkg::xdata_t'(`SFU_CORE_ID);
            sfu_csr_pkg::CSR_TMASK:     rd_data = sfu_op_pkg::xdata_t'(exec_tmask);
            sfu_csr_pkg::CSR_NUM_WARPS: rd_data = sfu_op_pkg::xdata_t'(`SFU_NUM_WARPS);
            sfu_csr_pkg::CSR_INSTRET:   rd_data = instret;
            default:                    rd_data = '0;
        endcase
    end

    always_comb begin
        case (exec_op)
            sfu_op_pkg::CSRRW: wr_data = exec_rs1;
            sfu_op_pkg::CSRRS: wr_data = scratch | exec_rs1;
            sfu_op_pkg::CSRRC: wr_data = scratch & ~exec_rs1;
            default:           wr_data = scratch;
        endcase
    end

    // Only the scratch register is writable
    assign scratch_wr = fire && (exec_csr_addr == sfu_csr_pkg::CSR_SCRATCH);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
            scratch   <= '0;
            instret   <= '0;
        end else begin
            if (fire) begin
                res_valid <= 1'b1;
            end else if (res_ready) begin
                res_valid <= 1'b0;
            end
            if (scratch_wr) begin
                scratch <= wr_data;
            end
            if (retire) begin
                instret <= instret + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res_uuid  <= exec_uuid;
            res_wid   <= exec_wid;
            res_tmask <= exec_tmask;
            res_data  <= rd_data;
        end
    end

endmodule

// ==== logic/sfu_warp_ctl.sv ====
/*
 * Warp-control element
 * Thread-mask change, warp spawn and two-barrier synchronization with
 * one-cycle side-effect strobes and a one-entry result register
 */

`timescale 1ns/1ps

module sfu_warp_ctl (
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 exec_valid,
    input  sfu_op_pkg::uuid_t    exec_uuid,
    input  sfu_op_pkg::wid_t     exec_wid,
    input  sfu_op_pkg::tmask_t   exec_tmask,
    input  sfu_op_pkg::sfu_op_t  exec_op,
    input  sfu_op_pkg::xdata_t   exec_rs1,
    input  sfu_op_pkg::xdata_t   exec_rs2,
    output logic                 exec_ready,

    output logic                 res_valid,
    output sfu_op_pkg::uuid_t    res_uuid,
    output sfu_op_pkg::wid_t     res_wid,
    output sfu_op_pkg::tmask_t   res_tmask,
    output logic                 res_wb,
    output sfu_op_pkg::xdata_t   res_data,
    input  logic                 res_ready,

    output logic                 tmc_valid,
    output sfu_op_pkg::wid_t     tmc_wid,
    output sfu_op_pkg::tmask_t   tmc_mask,
    output logic                 spawn_valid,
    output sfu_op_pkg::wmask_t   spawn_mask,
    output sfu_op_pkg::xdata_t   spawn_pc,
    output logic                 bar_release_valid,
    output sfu_op_pkg::wmask_t   bar_release_mask
);

    localparam int NUM_BARS = 2;
    localparam int CNT_W    = $clog2($bits(sfu_op_pkg::wmask_t) + 1);

    logic                fire;
    logic                bar_fire;
    logic                bar_id;
    logic                bar_done;
    sfu_op_pkg::wmask_t  bar_arrived;
    logic [CNT_W-1:0]    bar_next_cnt;

    // Arrived warps and arrival count per barrier
    sfu_op_pkg::wmask_t  bar_mask [NUM_BARS];
    logic [CNT_W-1:0]    bar_cnt  [NUM_BARS];

    assign exec_ready = !res_valid || res_ready;
    assign fire       = exec_valid && exec_ready;
    assign bar_fire   = fire && (exec_op == sfu_op_pkg::BAR);

    assign bar_id       = exec_rs1[0];
    assign bar_arrived  = bar_mask[bar_id] | (sfu_op_pkg::wmask_t'(1) << exec_wid);
    assign bar_next_cnt = bar_cnt[bar_id] + 1'b1;
    // Release on the arrival that reaches the requested warp count
    assign bar_done     = sfu_op_pkg::xdata_t'(bar_next_cnt) >= exec_rs2;

    // Warp-control operations never write back a register
    assign res_wb   = 1'b0;
    assign res_data = '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid         <= 1'b0;
            tmc_valid         <= 1'b0;
            spawn_valid       <= 1'b0;
            bar_release_valid <= 1'b0;
            bar_mask          <= '{default: '0};
            bar_cnt           <= '{default: '0};
        end else begin
            if (fire) begin
                res_valid <= 1'b1;
            end else if (res_ready) begin
                res_valid <= 1'b0;
            end
            tmc_valid         <= fire && (exec_op == sfu_op_pkg::TMC);
            spawn_valid       <= fire && (exec_op == sfu_op_pkg::WSPAWN);
            bar_release_valid <= bar_fire && bar_done;
            if (bar_fire) begin
                if (bar_done) begin
                    bar_mask[bar_id] <= '0;
                    bar_cnt[bar_id]  <= '0;
                end else begin
                    bar_mask[bar_id] <= bar_arrived;
                    bar_cnt[bar_id]  <= bar_next_cnt;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res_uuid         <= exec_uuid;
            res_wid          <= exec_wid;
            res_tmask        <= exec_tmask;
            tmc_wid          <= exec_wid;
            tmc_mask         <= sfu_op_pkg::tmask_t'(exec_rs1);
            spawn_mask       <= sfu_op_pkg::wmask_t'(exec_rs1);
            spawn_pc         <= exec_rs2;
            bar_release_mask <= bar_arrived;
        end
    end

endmodule

// ==== logic/sfu_pe_switch.sv ====
/*
 * Request steering and result arbitration between the two elements
 * Decodes the operation class, forwards the request in the same cycle and
 * merges the element results round-robin into a one-entry commit register
 */

`timescale 1ns/1ps

module sfu_pe_switch (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    req_valid,
    input  sfu_op_pkg::uuid_t       req_uuid,
    input  sfu_op_pkg::wid_t        req_wid,
    input  sfu_op_pkg::tmask_t      req_tmask,
    input  sfu_op_pkg::sfu_op_t     req_op,
    input  sfu_csr_pkg::csr_addr_t  req_csr_addr,
    input  sfu_op_pkg::xdata_t      req_rs1,
    input  sfu_op_pkg::xdata_t      req_rs2,
    output logic                    req_ready,

    output logic                    commit_valid,
    output sfu_op_pkg::uuid_t       commit_uuid,
    output sfu_op_pkg::wid_t        commit_wid,
    output sfu_op_pkg::tmask_t      commit_tmask,
    output logic                    commit_wb,
    output sfu_op_pkg::xdata_t      commit_data,
    input  logic                    commit_ready,

    output sfu_op_pkg::uuid_t       exec_uuid,
    output sfu_op_pkg::wid_t        exec_wid,
    output sfu_op_pkg::tmask_t      exec_tmask,
    output sfu_op_pkg::sfu_op_t     exec_op,
    output sfu_csr_pkg::csr_addr_t  exec_csr_addr,
    output sfu_op_pkg::xdata_t      exec_rs1,
    output sfu_op_pkg::xdata_t      exec_rs2,
    output logic                    wctl_valid,
    input  logic                    wctl_ready,
    output logic                    csr_valid,
    input  logic                    csr_ready,

    input  logic                    wctl_res_valid,
    input  sfu_op_pkg::uuid_t       wctl_res_uuid,
    input  sfu_op_pkg::wid_t        wctl_res_wid,
    input  sfu_op_pkg::tmask_t      wctl_res_tmask,
    input  logic                    wctl_res_wb,
    input  sfu_op_pkg::xdata_t      wctl_res_data,
    output logic                    wctl_res_ready,

    input  logic                    csr_res_valid,
    input  sfu_op_pkg::uuid_t       csr_res_uuid,
    input  sfu_op_pkg::wid_t        csr_res_wid,
    input  sfu_op_pkg::tmask_t      csr_res_tmask,
    input  logic                    csr_res_wb,
    input  sfu_op_pkg::xdata_t      csr_res_data,
    output logic                    csr_res_ready
);

    logic sel_csr;
    logic commit_free;
    logic res_any;
    logic grant_csr;
    // Set when the CSR element won the last grant
    logic last_csr;

    assign sel_csr    = sfu_op_pkg::is_csr_op(req_op);
    assign wctl_valid = req_valid && !sel_csr;
    assign csr_valid  = req_valid && sel_csr;
    assign req_ready  = sel_csr ? csr_ready : wctl_ready;

    assign exec_uuid     = req_uuid;
    assign exec_wid      = req_wid;
    assign exec_tmask    = req_tmask;
    assign exec_op       = req_op;
    assign exec_csr_addr = req_csr_addr;
    assign exec_rs1      = req_rs1;
    assign exec_rs2      = req_rs2;

    // The commit register takes a new entry when empty or when it drains this cycle
    assign commit_free = !commit_valid || commit_ready;
    assign res_any     = wctl_res_valid || csr_res_valid;

    always_comb begin
        if (wctl_res_valid && csr_res_valid) begin
            grant_csr = !last_csr;
        end else begin
            grant_csr = csr_res_valid;
        end
    end

    assign wctl_res_ready = commit_free && !grant_csr;
    assign csr_res_ready  = commit_free && grant_csr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid <= 1'b0;
            last_csr     <= 1'b1;
        end else if (commit_free) begin
            commit_valid <= res_any;
            if (res_any) begin
                last_csr <= grant_csr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commit_free && res_any) begin
            if (grant_csr) begin
                commit_uuid  <= csr_res_uuid;
                commit_wid   <= csr_res_wid;
                commit_tmask <= csr_res_tmask;
                commit_wb    <= csr_res_wb;
                commit_data  <= csr_res_data;
            end else begin
                commit_uuid  <= wctl_res_uuid;
                commit_wid   <= wctl_res_wid;
                commit_tmask <= wctl_res_tmask;
                commit_wb    <= wctl_res_wb;
                commit_data  <= wctl_res_data;
            end
        end
    end

endmodule

// ==== logic/sfu_csr_pkg.sv ====
/*
 * CSR-side types of the special-function unit
 * CSR address type and the addresses the CSR element decodes
 */

package sfu_csr_pkg;

    typedef logic [11:0] csr_addr_t;

    // Read and write
    localparam csr_addr_t CSR_SCRATCH   = 12'h340;

    // Read only, writes to these are dropped
    localparam csr_addr_t CSR_INSTRET   = 12'hB02;
    localparam csr_addr_t CSR_WARP_ID   = 12'hCC1;
    localparam csr_addr_t CSR_CORE_ID   = 12'hCC2;
    localparam csr_addr_t CSR_TMASK     = 12'hCC4;
    localparam csr_addr_t CSR_NUM_WARPS = 12'hFC1;

endpackage

// ==== logic/sfu_op_pkg.sv ====
/*
 * Instruction-side types of the special-function unit
 * Warp index, lane and warp masks, tag and data words, the operation enum
 * and the operation class decode
 */

`include "sfu_cfg.svh"

package sfu_op_pkg;

    typedef logic [$clog2(`SFU_NUM_WARPS)-1:0] wid_t;
    typedef logic [`SFU_NUM_LANES-1:0]         tmask_t;
    typedef logic [`SFU_NUM_WARPS-1:0]         wmask_t;
    typedef logic [`SFU_UUID_W-1:0]            uuid_t;
    typedef logic [`SFU_XLEN-1:0]              xdata_t;

    typedef enum logic [2:0] {
        TMC    = 3'd0,
        WSPAWN = 3'd1,
        BAR    = 3'd2,
        CSRRW  = 3'd3,
        CSRRS  = 3'd4,
        CSRRC  = 3'd5
    } sfu_op_t;

    // CSR accesses go to the CSR element, all other operations to warp control
    function automatic logic is_csr_op(sfu_op_t op);
        return (op == CSRRW) || (op == CSRRS) || (op == CSRRC);
    endfunction

endpackage

// ==== logic/sfu_cfg.svh ====
/*
 * Configuration macros of the special-function unit
 * Warp count, lane count, core id, data width and instruction tag width
 */

`ifndef SFU_CFG_SVH
`define SFU_CFG_SVH

`define SFU_NUM_WARPS 8
`define SFU_NUM_LANES 4
`define SFU_CORE_ID   3
`define SFU_XLEN      32
`define SFU_UUID_W    8

`endif
